// File: tb.f
+incdir+design
design/dmem_pkg.sv
design/dmem_if.sv
design/uart_rx.sv
design/upg_loader.sv
design/dmemory32.sv
design/data_ram.sv
design/dmem_top.sv
test/tb_dmem_top.sv

// File: run.sh
#!/bin/sh
# Build the data memory testbench with Verilator and run it
# Exit status is zero only when the pass line appears

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f \
  --top-module tb_dmem_top -o tb_dmem_top || { echo "Build failed"; exit 1; }

out=$(./obj_dir/tb_dmem_top)
echo "$out"

echo "$out" | grep -qx "Test OK" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: test/tb_dmem_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmem_cfg.svh"

module tb_dmem_top import dmem_pkg::*; ();

  localparam int CLK_NS  = 10;
  localparam int BIT_NS  = `DMEM_UART_DIV * CLK_NS;             // One UART bit on the line
  localparam int LOAD_NS = `DMEM_UPG_WORDS * 4 * 10 * BIT_NS;  // Four 10 bit frames per word
  localparam int WORDS   = `DMEM_UPG_WORDS;

  typedef enum logic [2:0] {
    OP_RESET,    // Reset pulse with prog_en_i from wdata[0]
    OP_LOAD,     // UART load of the word set in addr
    OP_WR,       // CPU write that must land
    OP_WR_PROG,  // Dropped CPU write during programming
    OP_RD,       // CPU read checked against the model
    OP_RD_PROG,  // Masked CPU read during programming
    OP_DONE      // Check upg_done_o against exp[0]
  } op_e;

  typedef struct {
    op_e        op;
    byte_addr_t addr;
    word_t      wdata;
    word_t      exp;
  } row_t;

  logic       clock;
  logic       rst_n;
  logic       prog_en;
  logic       uart_rx;
  logic       mem_write;
  byte_addr_t address;
  word_t      write_data;
  word_t      read_data;
  logic       upg_done;

  row_t        rows[$];                  // Stimulus table
  word_t       load_words [2 * WORDS];   // Two load sets
  word_t       model [`DMEM_DEPTH];      // Expected RAM contents
  logic [31:0] lcg_state;
  int          n_loads;
  int          errors;
  int          checks;
  logic        table_ready;

  initial clock = 1'b0;
  always #(CLK_NS / 2) clock = ~clock;  // 100 MHz

  dmem_top uut (
    .clock_i      (clock),
    .rst_n_i      (rst_n),
    .prog_en_i    (prog_en),
    .uart_rx_i    (uart_rx),
    .mem_write_i  (mem_write),
    .address_i    (address),
    .write_data_i (write_data),
    .read_data_o  (read_data),
    .upg_done_o   (upg_done)
  );

  //////////////////////////////////////////////////
  // Table construction
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected value follows the memory rules at build time
  task automatic add_row(input op_e op, input byte_addr_t addr, input word_t wdata);
    row_t r;
    int   i;
    r.op    = op;
    r.addr  = addr;
    r.wdata = wdata;
    r.exp   = '0;
    case (op)
      OP_LOAD: begin
        for (i = 0; i < WORDS; i++) model[i] = load_words[int'(addr) * WORDS + i];
        n_loads++;
      end
      OP_WR:   model[addr[`DMEM_ADDR_W+1:2]] = wdata;  // Word from byte address
      OP_RD:   r.exp = model[addr[`DMEM_ADDR_W+1:2]];
      OP_DONE: r.exp = wdata;
      default: ;  // No model update for the rest
    endcase
    rows.push_back(r);
  endtask

  task automatic add_write(input op_e op, input byte_addr_t addr);
    lcg_state = lcg_next(lcg_state);
    add_row(op, addr, lcg_state);
  endtask

  task automatic build_table();
    int i;
    lcg_state = 32'h6397;
    for (i = 0; i < 2 * WORDS; i++) begin
      lcg_state     = lcg_next(lcg_state);
      load_words[i] = lcg_state;
    end
    // First phase loads and then checks CPU access
    add_row(OP_RESET, '0, 32'd1);
    add_row(OP_DONE, '0, 32'd0);
    add_row(OP_RD_PROG, 32'h0, '0);   // Masked before load
    add_row(OP_RD_PROG, 32'h14, '0);
    add_row(OP_LOAD, 32'd0, '0);
    add_row(OP_DONE, '0, 32'd1);
    for (i = 0; i < WORDS; i++) add_row(OP_RD, byte_addr_t'(4 * i), '0);
    add_write(OP_WR, 32'h43);         // Low bits ignored
    add_row(OP_RD, 32'h40, '0);
    add_row(OP_RD, 32'h42, '0);
    add_write(OP_WR, 32'hFFFC);       // Last word
    add_row(OP_RD, 32'hFFFF, '0);
    add_write(OP_WR, 32'h8);          // Overwrite a loaded word
    add_row(OP_RD, 32'hB, '0);
    add_row(OP_RD, 32'h4, '0);
    add_row(OP_DONE, '0, 32'd1);
    // Second phase drops CPU writes before the load completes
    add_row(OP_RESET, '0, 32'd1);
    add_row(OP_DONE, '0, 32'd0);
    add_write(OP_WR_PROG, 32'hC);
    add_write(OP_WR_PROG, 32'h40);    // Word outside the load
    add_row(OP_RD_PROG, 32'hC, '0);
    add_row(OP_RD_PROG, 32'h40, '0);  // Holds data but still masked
    add_row(OP_LOAD, 32'd1, '0);
    add_row(OP_DONE, '0, 32'd1);
    add_row(OP_RD, 32'hC, '0);
    for (i = 0; i < WORDS; i++) add_row(OP_RD, byte_addr_t'(4 * i), '0);
    add_row(OP_RD, 32'h40, '0);       // Old word kept over reset and the dropped write
    // Third phase runs without any programming
    add_row(OP_RESET, '0, 32'd0);
    add_row(OP_DONE, '0, 32'd0);
    add_write(OP_WR, 32'h100);
    add_row(OP_RD, 32'h100, '0);
    add_write(OP_WR, 32'h1FD);
    add_row(OP_RD, 32'h1FC, '0);
    add_row(OP_RD, 32'h4, '0);
    add_row(OP_DONE, '0, 32'd0);
  endtask

  //////////////////////////////////////////////////
  // Drivers and checks
  //////////////////////////////////////////////////

  task automatic apply_reset(input logic prog);
    @(posedge clock);
    #1;
    rst_n     = 1'b0;
    prog_en   = prog;
    mem_write = 1'b0;
    repeat (3) @(posedge clock);
    #1 rst_n = 1'b1;
  endtask

  // One UART bit of exactly DIV cycles
  task automatic line_bit(input logic v);
    @(posedge clock);
    #1 uart_rx = v;
    repeat (`DMEM_UART_DIV - 1) @(posedge clock);
  endtask

  task automatic send_byte(input byte_t b);
    int i;
    line_bit(1'b0);                            // Start bit
    for (i = 0; i < 8; i++) line_bit(b[i]);    // LSB first
    line_bit(1'b1);                            // Stop bit
  endtask

  task automatic send_load(input int set);
    int    w;
    int    k;
    word_t data;
    for (w = 0; w < WORDS; w++) begin
      data = load_words[set * WORDS + w];
      for (k = 0; k < 4; k++) send_byte(data[8*k +: 8]);  // Little endian
    end
    repeat (10) @(posedge clock);  // Done is due by now
  endtask

  task automatic cpu_write(input byte_addr_t addr, input word_t data);
    @(posedge clock);
    #1;
    mem_write  = 1'b1;
    address    = addr;
    write_data = data;
    @(posedge clock);
    #1 mem_write = 1'b0;
  endtask

  // Data is due one cycle after the address and sampled mid cycle
  task automatic cpu_read(input int idx, input row_t r);
    @(posedge clock);
    #1;
    mem_write = 1'b0;
    address   = r.addr;
    @(posedge clock);
    @(negedge clock);
    checks++;
    if (read_data !== r.exp) begin
      errors++;
      $display("Error: read_data_o row %0d addr %h got %h expected %h",
               idx, r.addr, read_data, r.exp);
    end
  endtask

  task automatic check_done(input int idx, input row_t r);
    @(negedge clock);
    checks++;
    if (upg_done !== r.exp[0]) begin
      errors++;
      $display("Error: upg_done_o row %0d got %h expected %h", idx, upg_done, r.exp[0]);
    end
  endtask

  //////////////////////////////////////////////////
  // Run
  //////////////////////////////////////////////////

  initial begin
    rst_n       = 1'b0;
    prog_en     = 1'b1;
    uart_rx     = 1'b1;  // Line idle
    mem_write   = 1'b0;
    address     = '0;
    write_data  = '0;
    errors      = 0;
    checks      = 0;
    n_loads     = 0;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    foreach (rows[i]) begin
      case (rows[i].op)
        OP_RESET:          apply_reset(rows[i].wdata[0]);
        OP_LOAD:           send_load(int'(rows[i].addr));
        OP_WR, OP_WR_PROG: cpu_write(rows[i].addr, rows[i].wdata);
        OP_RD, OP_RD_PROG: cpu_read(i, rows[i]);
        default:           check_done(i, rows[i]);
      endcase
    end
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Limit from load count and table length plus margin
  initial begin
    int limit_ns;
    wait (table_ready);
    limit_ns = n_loads * (LOAD_NS + 20 * CLK_NS) + rows.size() * 6 * CLK_NS + 50000;
    #(limit_ns);
    $display("Timeout: watchdog expired after %0d ns, table not finished", limit_ns);
    $display("Test FAILED");
    $finish;
  end

endmodule : tb_dmem_top

`default_nettype wire

// File: design/dmem_top.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_top import dmem_pkg::*; (
  input  wire             clock_i,
  input  wire             rst_n_i,
  input  wire             prog_en_i,     // High selects UART programming
  input  wire             uart_rx_i,     // Programmer serial line
  input  wire             mem_write_i,   // CPU write
  input  wire byte_addr_t address_i,     // CPU byte address
  input  wire word_t      write_data_i,  // CPU write data
  output word_t           read_data_o,   // CPU read data
  output logic            upg_done_o     // Programming finished
);

  //////////////////////////////////////////////////
  // Programmer path
  //////////////////////////////////////////////////

  byte_t      rx_byte;
  logic       rx_valid;
  logic       upg_we;
  word_addr_t upg_addr;
  word_t      upg_data;

  uart_rx u_uart_rx (
    .clock_i    (clock_i),
    .rst_n_i    (rst_n_i),
    .rx_i       (uart_rx_i),
    .rx_byte_o  (rx_byte),
    .rx_valid_o (rx_valid)
  );

  upg_loader u_upg_loader (
    .clock_i    (clock_i),
    .rst_n_i    (rst_n_i),
    .prog_en_i  (prog_en_i),
    .rx_byte_i  (rx_byte),
    .rx_valid_i (rx_valid),
    .upg_we_o   (upg_we),
    .upg_addr_o (upg_addr),
    .upg_data_o (upg_data),
    .upg_done_o (upg_done_o)  // Also feeds the selector
  );

  //////////////////////////////////////////////////
  // Memory
  //////////////////////////////////////////////////

  dmem_if ram_bus ();

  dmemory32 u_dmemory32 (
    .clock_i      (clock_i),
    .rst_n_i      (rst_n_i),
    .prog_en_i    (prog_en_i),
    .mem_write_i  (mem_write_i),
    .address_i    (address_i),
    .write_data_i (write_data_i),
    .read_data_o  (read_data_o),
    .upg_we_i     (upg_we),
    .upg_addr_i   (upg_addr),
    .upg_data_i   (upg_data),
    .upg_done_i   (upg_done_o),
    .ram          (ram_bus.req)
  );

  data_ram u_data_ram (
    .clock_i (clock_i),
    .ram     (ram_bus.mem)
  );

endmodule : dmem_top

`default_nettype wire

// File: design/data_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmem_cfg.svh"

// Single port word RAM, maps onto block RAM
module data_ram import dmem_pkg::*; (
  input wire  clock_i,
  dmem_if.mem ram
);

  //////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////

  word_t mem_q [`DMEM_DEPTH];  // Contents survive reset

  // Read first behaviour
  // A read of the written address returns the old word
  always_ff @(posedge clock_i) begin
    if (ram.we) begin
      mem_q[ram.addr] <= ram.wdata;
    end
    ram.rdata <= mem_q[ram.addr];  // Registered read, one cycle latency
  end

endmodule : data_ram

`default_nettype wire

// File: design/dmemory32.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmem_cfg.svh"

module dmemory32 import dmem_pkg::*; (
  input  wire             clock_i,
  input  wire             rst_n_i,
  input  wire             prog_en_i,     // Programming requested
  input  wire             mem_write_i,   // CPU write
  input  wire byte_addr_t address_i,     // CPU byte address
  input  wire word_t      write_data_i,  // CPU write data
  output word_t           read_data_o,   // CPU read data, one cycle later
  input  wire             upg_we_i,      // Loader write strobe
  input  wire word_addr_t upg_addr_i,    // Loader word address
  input  wire word_t      upg_data_i,    // Loader write data
  input  wire             upg_done_i,    // Loader finished
  dmem_if.req             ram            // To the word RAM
);

  //////////////////////////////////////////////////
  // Ownership
  //////////////////////////////////////////////////

  // CPU runs once programming is off or the load is complete
  wire kick_off = ~prog_en_i | upg_done_i;

  // Word address from the byte address
  wire word_addr_t cpu_addr = address_i[`DMEM_ADDR_W+1:2];

  assign ram.we    = kick_off ? mem_write_i  : upg_we_i;    // CPU writes dropped here
  assign ram.addr  = kick_off ? cpu_addr     : upg_addr_i;
  assign ram.wdata = kick_off ? write_data_i : upg_data_i;

  //////////////////////////////////////////////////
  // Read mask
  //////////////////////////////////////////////////

  logic prog_cycle_q;  // Previous cycle belonged to the loader

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      prog_cycle_q <= 1'b0;
    end else begin
      prog_cycle_q <= ~kick_off;
    end
  end

  // Lines up with the RAM read latency
  assign read_data_o = prog_cycle_q ? '0 : ram.rdata;

endmodule : dmemory32

`default_nettype wire

// File: design/upg_loader.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmem_cfg.svh"

module upg_loader import dmem_pkg::*; (
  input  wire        clock_i,
  input  wire        rst_n_i,
  input  wire        prog_en_i,   // Programming requested
  input  wire byte_t rx_byte_i,   // From the UART receiver
  input  wire        rx_valid_i,  // Byte strobe
  output logic       upg_we_o,    // One cycle write strobe
  output word_addr_t upg_addr_o,  // Running word address
  output word_t      upg_data_o,  // Assembled word
  output logic       upg_done_o   // Load complete, held until reset
);

  localparam word_addr_t LAST_ADDR = word_addr_t'(`DMEM_UPG_WORDS - 1);

  //////////////////////////////////////////////////
  // Byte packing
  //////////////////////////////////////////////////

  logic [1:0] byte_cnt_q;  // Bytes already in the word
  word_t      word_q;      // Little endian assembly
  word_addr_t addr_q;
  logic       we_q;
  logic       done_q;

  // Bytes count only while programming and not finished
  wire accept    = rx_valid_i & prog_en_i & ~done_q;
  wire word_full = accept & (byte_cnt_q == 2'd3);

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      byte_cnt_q <= '0;
    end else if (accept) begin
      byte_cnt_q <= byte_cnt_q + 1'b1;  // Wraps after the fourth byte
    end
  end

  // First byte ends up in bits 7:0 after four shifts
  always_ff @(posedge clock_i) begin
    if (accept) begin
      word_q <= {rx_byte_i, word_q[31:8]};
    end
  end

  //////////////////////////////////////////////////
  // Write strobe, address and completion
  //////////////////////////////////////////////////

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      we_q   <= 1'b0;
      addr_q <= '0;
      done_q <= 1'b0;
    end else begin
      we_q <= word_full;  // Write one cycle after the fourth byte
      if (we_q) begin
        addr_q <= addr_q + 1'b1;  // Next word after this write
        // Address doubles as the word count
        if (addr_q == LAST_ADDR) done_q <= 1'b1;
      end
    end
  end

  assign upg_we_o   = we_q;
  assign upg_addr_o = addr_q;  // Still the current word during the strobe
  assign upg_data_o = word_q;  // Complete while we_q is high
  assign upg_done_o = done_q;

endmodule : upg_loader

`default_nettype wire

// File: design/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none
`include "dmem_cfg.svh"

module uart_rx import dmem_pkg::*; (
  input  wire   clock_i,
  input  wire   rst_n_i,
  input  wire   rx_i,        // Serial line, idles high
  output byte_t rx_byte_o,   // Last received byte
  output logic  rx_valid_o   // One cycle strobe per good frame
);

  localparam int CNT_W = $clog2(`DMEM_UART_DIV);

  //////////////////////////////////////////////////
  // Line synchronizer
  //////////////////////////////////////////////////

  logic rx_meta_q;
  logic rx_sync_q;

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      rx_meta_q <= 1'b1;  // Idle level
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  //////////////////////////////////////////////////
  // Frame FSM
  //////////////////////////////////////////////////

  rx_state_e        state_q;
  logic [CNT_W-1:0] cnt_q;     // Cycles within the current bit
  logic [2:0]       bit_idx_q; // Data bit being sampled
  byte_t            shift_q;   // Data bits, shifted in from the top

  wire half_done = (cnt_q == CNT_W'(`DMEM_UART_DIV / 2 - 1));
  wire bit_done  = (cnt_q == CNT_W'(`DMEM_UART_DIV - 1));

  always_ff @(posedge clock_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      cnt_q      <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;  // Strobe by default low
      cnt_q      <= cnt_q + 1'b1;
      case (state_q)
        IDLE: begin
          cnt_q <= '0;
          if (!rx_sync_q) state_q <= START;  // Falling edge seen
        end
        START: begin
          if (half_done) begin
            cnt_q     <= '0;
            bit_idx_q <= '0;
            // Glitch shorter than half a bit goes back to idle
            state_q   <= rx_sync_q ? IDLE : DATA;
          end
        end
        DATA: begin
          if (bit_done) begin
            cnt_q     <= '0;
            bit_idx_q <= bit_idx_q + 1'b1;
            if (bit_idx_q == 3'd7) state_q <= STOP;  // Last data bit
          end
        end
        STOP: begin
          if (bit_done) begin
            rx_valid_o <= rx_sync_q;  // Framing error drops the byte
            state_q    <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // LSB arrives first, so shift right
  always_ff @(posedge clock_i) begin
    if (state_q == DATA && bit_done) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign rx_byte_o = shift_q;

endmodule : uart_rx

`default_nettype wire

// File: design/dmem_if.sv
`timescale 1ns/1ps
`default_nettype none

// One access per cycle between a requester and the word RAM
interface dmem_if import dmem_pkg::*; ();

  logic       we;     // Write strobe for this cycle
  word_addr_t addr;   // Word address
  word_t      wdata;  // Write data
  word_t      rdata;  // Read data, one cycle after addr

  // Requester side, selector in front of the RAM
  modport req (
    output we,
    output addr,
    output wdata,
    input  rdata
  );

  // Memory side
  modport mem (
    input  we,
    input  addr,
    input  wdata,
    output rdata
  );

endinterface : dmem_if

`default_nettype wire

// File: design/dmem_pkg.sv
`default_nettype none
`include "dmem_cfg.svh"

package dmem_pkg;

  // Data path widths
  typedef logic [31:0] word_t;       // One memory word
  typedef logic [31:0] byte_addr_t;  // CPU side address, unit is byte
  typedef logic [7:0]  byte_t;       // One UART payload byte

  // RAM side address, unit is word
  typedef logic [`DMEM_ADDR_W-1:0] word_addr_t;

  // Receiver FSM
  typedef enum logic [1:0] {
    IDLE,   // Line high, waiting for a falling edge
    START,  // Checking start bit at mid period
    DATA,   // Eight data bits, LSB first
    STOP    // Stop bit check
  } rx_state_e;

endpackage : dmem_pkg

`default_nettype wire

// File: design/dmem_cfg.svh
`ifndef DMEM_CFG_SVH
`define DMEM_CFG_SVH

//////////////////////////////////////////////////
// Memory geometry
//////////////////////////////////////////////////

`define DMEM_ADDR_W    14     // Word address bits, byte address 15:2
`define DMEM_DEPTH     16384  // Words in the RAM, 64 KiB

//////////////////////////////////////////////////
// UART programmer
//////////////////////////////////////////////////

// Clock cycles per bit on the line
`define DMEM_UART_DIV  8

// Words in one programming load
`define DMEM_UPG_WORDS 8

`endif
